// File: Bender.yml
package:
  name: ft_alu

sources:
  - ft_alu_pkg.sv
  - ft_csr_pkg.sv
  - alu_core.sv
  - tmr_voter.sv
  - replica_vote.sv
  - err_counter_bank.sv
  - ft_alu_top.sv
  - target: simulation
    files:
      - ft_alu_sva.sv
      - tb_ft_alu.sv

// File: alu_core.sv
module alu_core import ft_alu_pkg::*; (
	input  logic     clk,
	input  logic     rst_i,
	input  alu_req_t req_i,
	output alu_rsp_t rsp_o
);

	logic [DATA_W-1:0] alu_res;
	logic              alu_cmp;

	logic              valid_q;
	logic              cmp_q;
	logic [DATA_W-1:0] res_q;

	////////////////////////////////////////
	// operation decode

	always_comb begin
		alu_res = '0;
		alu_cmp = 1'b0;
		case (req_i.op)
			ALU_ADD: alu_res = req_i.a + req_i.b;
			ALU_SUB: begin
				alu_res = req_i.a - req_i.b;
				alu_cmp = (alu_res == '0);  // equality test through sub
			end
			ALU_AND: alu_res = req_i.a & req_i.b;
			ALU_OR:  alu_res = req_i.a | req_i.b;
			ALU_XOR: alu_res = req_i.a ^ req_i.b;
			ALU_SLL: alu_res = req_i.a << req_i.b[4:0];
			ALU_SRL: alu_res = req_i.a >> req_i.b[4:0];
			ALU_SLT: begin
				alu_cmp = ($signed(req_i.a) < $signed(req_i.b));
				alu_res = {{(DATA_W-1){1'b0}}, alu_cmp};
			end
			ALU_SLTU: begin
				alu_cmp = (req_i.a < req_i.b);
				alu_res = {{(DATA_W-1){1'b0}}, alu_cmp};
			end
			default: ;  // unused encodings give zero
		endcase
	end

	////////////////////////////////////////
	// output register

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_i.en;  // one cycle latency, no back-pressure
		end
	end

	always_ff @(posedge clk) begin
		if (req_i.en) begin
			res_q <= alu_res;
			cmp_q <= alu_cmp;
		end
	end

	assign rsp_o.valid  = valid_q;
	assign rsp_o.cmp    = cmp_q;
	assign rsp_o.result = res_q;

endmodule

// File: err_counter_bank.sv
module err_counter_bank import ft_alu_pkg::*, ft_csr_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic [NUM_REPLICAS-1:0] err_replica_i,
	input  wb_req_t                 wb_i,
	output logic                    wb_ack_o,
	output logic [WB_DAT_W-1:0]     wb_dat_o,
	output logic [NUM_REPLICAS-1:0] faulty_o
);

	logic [NUM_REPLICAS-1:0][CNT_W-1:0] cnt_q;
	logic [NUM_REPLICAS-1:0][CNT_W-1:0] cnt_inc;
	logic [NUM_REPLICAS-1:0]            faulty_q;

	logic                  ack_q;
	logic [WB_DAT_W-1:0]   dat_q;
	logic [WB_DAT_W-1:0]   rd_data;
	logic                  wb_access;
	logic                  wb_write;
	logic                  cnt_sel;
	logic [REP_IDX_W-1:0]  cnt_idx;
	logic [CNT_W-1:0]      wr_cnt;

	////////////////////////////////////////
	// wishbone decode

	assign wb_access = wb_i.cyc & wb_i.stb & ~ack_q;  // no second ack while stb is still up
	assign wb_write  = wb_access & wb_i.we;
	assign cnt_sel   = (wb_i.adr < ADDR_W'(NUM_REPLICAS));
	assign cnt_idx   = wb_i.adr[REP_IDX_W-1:0];
	assign wr_cnt    = wb_i.dat[CNT_W-1:0];

	always_comb begin
		if (cnt_sel) begin
			rd_data = WB_DAT_W'(cnt_q[cnt_idx]);
		end else if (wb_i.adr == REG_FLAGS_ADDR) begin
			rd_data = WB_DAT_W'(faulty_q);
		end else begin
			rd_data = '0;  // unmapped
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_access;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_access) begin
			dat_q <= rd_data;
		end
	end

	////////////////////////////////////////
	// counters and fault flags

	always_comb begin
		for (int i = 0; i < NUM_REPLICAS; i++) begin
			cnt_inc[i] = cnt_q[i] + CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cnt_q    <= '0;
			faulty_q <= '0;
		end else begin
			for (int i = 0; i < NUM_REPLICAS; i++) begin
				if (wb_write && cnt_sel && cnt_idx == REP_IDX_W'(i)) begin
					// software write wins over a same-cycle error
					cnt_q[i]    <= wr_cnt;
					faulty_q[i] <= (wr_cnt >= FAULT_THRESHOLD);
				end else if (err_replica_i[i] && cnt_q[i] != '1) begin
					cnt_q[i] <= cnt_inc[i];  // saturates at all ones
					if (cnt_inc[i] >= FAULT_THRESHOLD) begin
						faulty_q[i] <= 1'b1;  // sticky
					end
				end
			end
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign faulty_o = faulty_q;

endmodule

// File: ft_alu_pkg.sv
package ft_alu_pkg;

	////////////////////////////////////////
	// datapath sizes

	localparam int DATA_W       = 32;
	localparam int NUM_REPLICAS = 4;
	localparam int NUM_SLOTS    = 3;  // voting slots fed by the spare mux
	localparam int SPARE_IDX    = NUM_REPLICAS - 1;  // replica that can stand in for any slot
	localparam int REP_IDX_W    = $clog2(NUM_REPLICAS);

	////////////////////////////////////////
	// operations

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SLT  = 4'd7,
		ALU_SLTU = 4'd8
	} alu_op_e;

	// one replica's request, 69 bits
	typedef struct packed {
		logic              en;
		alu_op_e           op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} alu_req_t;

	// one replica's response, 34 bits
	typedef struct packed {
		logic              valid;
		logic              cmp;     // comparison flag
		logic [DATA_W-1:0] result;
	} alu_rsp_t;

endpackage

// File: ft_alu_sva.sv
module ft_alu_sva import ft_alu_pkg::*, ft_csr_pkg::*; (
	input logic                               clk,
	input logic                               rst_i,
	input wb_req_t                            wb_i,
	input logic                               wb_ack_i,
	input logic                               corrected_i,
	input logic                               detected_i,
	input logic [NUM_REPLICAS-1:0][CNT_W-1:0] cnt_i
);

	int fails = 0;  // failed assertions so far

	////////////////////////////////////////
	// wishbone handshake

	assert property (@(posedge clk) disable iff (rst_i) wb_ack_i |=> !wb_ack_i) else begin
		fails++;
		$error("wb ack held longer than one cycle");
	end

	assert property (@(posedge clk) disable iff (rst_i)
		wb_ack_i |-> $past(wb_i.cyc && wb_i.stb)) else begin
		fails++;
		$error("wb ack without a strobe on the cycle before");
	end

	////////////////////////////////////////
	// error flags and counters

	assert property (@(posedge clk) disable iff (rst_i) corrected_i |-> detected_i) else begin
		fails++;
		$error("corrected error not flagged as detected");
	end

	for (genvar i = 0; i < NUM_REPLICAS; i++) begin : g_cnt
		assert property (@(posedge clk) disable iff (rst_i)
			(cnt_i[i] < $past(cnt_i[i]))
			|-> $past(wb_i.cyc && wb_i.stb && wb_i.we && wb_i.adr == ADDR_W'(i))) else begin
			fails++;
			$error("error counter %0d went down without a write", i);
		end
	end

endmodule

bind ft_alu_top ft_alu_sva u_ft_alu_sva (
	.clk         ( clk                      ),
	.rst_i       ( rst_i                    ),
	.wb_i        ( wb_i                     ),
	.wb_ack_i    ( wb_ack_o                 ),
	.corrected_i ( err_corrected_o          ),
	.detected_i  ( err_detected_o           ),
	.cnt_i       ( u_err_counter_bank.cnt_q )
);

// File: ft_alu_top.sv
module ft_alu_top import ft_alu_pkg::*, ft_csr_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_i,
	input  alu_req_t [NUM_REPLICAS-1:0]   req_i,        // own copy per replica
	input  logic [NUM_SLOTS-1:0]          sel_spare_i,
	input  logic [1:0]                    sel_bypass_i,
	output logic [DATA_W-1:0]             result_o,
	output logic                          comparison_o,
	output logic                          result_valid_o,
	output logic                          err_corrected_o,
	output logic                          err_detected_o,
	output logic [NUM_REPLICAS-1:0]       faulty_o,
	input  wb_req_t                       wb_i,
	output logic                          wb_ack_o,
	output logic [WB_DAT_W-1:0]           wb_dat_o
);

	alu_rsp_t [NUM_REPLICAS-1:0] rep_rsp;
	alu_rsp_t                    vote_rsp;
	logic [NUM_REPLICAS-1:0]     err_replica;

	////////////////////////////////////////
	// replicas

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : g_replica
		alu_core u_alu_core (
			.clk   ( clk        ),
			.rst_i ( rst_i      ),
			.req_i ( req_i[r]   ),
			.rsp_o ( rep_rsp[r] )
		);
	end

	replica_vote u_replica_vote (
		.rsp_i           ( rep_rsp         ),
		.sel_spare_i     ( sel_spare_i     ),
		.sel_bypass_i    ( sel_bypass_i    ),
		.rsp_o           ( vote_rsp        ),
		.err_corrected_o ( err_corrected_o ),
		.err_detected_o  ( err_detected_o  ),
		.err_replica_o   ( err_replica     )
	);

	err_counter_bank u_err_counter_bank (
		.clk           ( clk         ),
		.rst_i         ( rst_i       ),
		.err_replica_i ( err_replica ),
		.wb_i          ( wb_i        ),
		.wb_ack_o      ( wb_ack_o    ),
		.wb_dat_o      ( wb_dat_o    ),
		.faulty_o      ( faulty_o    )
	);

	assign result_o       = vote_rsp.result;
	assign comparison_o   = vote_rsp.cmp;
	assign result_valid_o = vote_rsp.valid;

endmodule

// File: ft_csr_pkg.sv
package ft_csr_pkg;

	////////////////////////////////////////
	// error counters

	localparam int CNT_W = 8;
	// count at which a replica is taken as permanently faulty
	localparam logic [CNT_W-1:0] FAULT_THRESHOLD = CNT_W'(4);

	////////////////////////////////////////
	// register map, word addresses
	// 0..3 error counter of replica 0..3
	// 4    permanent fault flags, one bit per replica, read only

	localparam int ADDR_W   = 3;
	localparam int WB_DAT_W = 32;
	localparam logic [ADDR_W-1:0] REG_FLAGS_ADDR = ADDR_W'(4);

	// wishbone classic request from the master, 38 bits
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [ADDR_W-1:0]   adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

endpackage

// File: list.f
ft_alu_pkg.sv
ft_csr_pkg.sv
alu_core.sv
tmr_voter.sv
replica_vote.sv
err_counter_bank.sv
ft_alu_top.sv
ft_alu_sva.sv
tb_ft_alu.sv

// File: replica_vote.sv
module replica_vote import ft_alu_pkg::*; (
	input  alu_rsp_t [NUM_REPLICAS-1:0] rsp_i,
	input  logic [NUM_SLOTS-1:0]        sel_spare_i,   // slot k takes the spare replica
	input  logic [1:0]                  sel_bypass_i,  // 0 voted, 1..3 raw slot
	output alu_rsp_t                    rsp_o,
	output logic                        err_corrected_o,
	output logic                        err_detected_o,
	output logic [NUM_REPLICAS-1:0]     err_replica_o
);

	alu_rsp_t [NUM_SLOTS-1:0] slot;
	alu_rsp_t                 voted;
	logic [NUM_SLOTS-1:0]     mismatch;
	logic                     no_majority;
	logic                     vote_ok;

	////////////////////////////////////////
	// spare select

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			slot[k] = sel_spare_i[k] ? rsp_i[SPARE_IDX] : rsp_i[k];
		end
	end

	tmr_voter u_tmr_voter (
		.slot_i        ( slot        ),
		.voted_o       ( voted       ),
		.mismatch_o    ( mismatch    ),
		.no_majority_o ( no_majority )
	);

	////////////////////////////////////////
	// bypass and error flags

	always_comb begin
		case (sel_bypass_i)
			2'd0:    rsp_o = voted;
			default: rsp_o = slot[sel_bypass_i - 2'd1];  // unvoted path
		endcase
	end

	assign vote_ok = voted.valid & rsp_o.valid;

	assign err_detected_o  = vote_ok & (|mismatch);
	// with two slots in agreement only the odd one can mismatch
	assign err_corrected_o = vote_ok & (|mismatch) & ~no_majority;

	// charge each slot mismatch to the replica wired into that slot
	always_comb begin
		err_replica_o = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			err_replica_o[k]         = err_replica_o[k] | (vote_ok & mismatch[k] & ~sel_spare_i[k]);
			err_replica_o[SPARE_IDX] = err_replica_o[SPARE_IDX]
			                         | (vote_ok & mismatch[k] & sel_spare_i[k]);
		end
	end

endmodule

// File: tb_ft_alu.sv
module tb_ft_alu import ft_alu_pkg::*, ft_csr_pkg::*; ();

	logic                        clk;
	logic                        rst_i;
	alu_req_t [NUM_REPLICAS-1:0] req;
	logic [NUM_SLOTS-1:0]        sel_spare;
	logic [1:0]                  sel_bypass;
	wb_req_t                     wb;
	logic [DATA_W-1:0]           result;
	logic                        comparison;
	logic                        result_valid;
	logic                        err_corrected;
	logic                        err_detected;
	logic [NUM_REPLICAS-1:0]     faulty;
	logic                        wb_ack;
	logic [WB_DAT_W-1:0]         wb_dat;

	logic [31:0] fld [0:11];  // fields of the current data line
	string       lines [$];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit  = 1000;  // reset once the data lines are known

	ft_alu_top u_ft_alu_top (
		.clk             ( clk           ),
		.rst_i           ( rst_i         ),
		.req_i           ( req           ),
		.sel_spare_i     ( sel_spare     ),
		.sel_bypass_i    ( sel_bypass    ),
		.result_o        ( result        ),
		.comparison_o    ( comparison    ),
		.result_valid_o  ( result_valid  ),
		.err_corrected_o ( err_corrected ),
		.err_detected_o  ( err_detected  ),
		.faulty_o        ( faulty        ),
		.wb_i            ( wb            ),
		.wb_ack_o        ( wb_ack        ),
		.wb_dat_o        ( wb_dat        )
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// one operation with its response registered on the next edge
	task automatic issue_op();
		@(negedge clk);
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			req[r].en = 1'b1;
			req[r].op = alu_op_e'(fld[0][3:0]);
			req[r].a  = fld[1 + r];  // own operand per replica
			req[r].b  = fld[5];
		end
		sel_spare  = fld[6][NUM_SLOTS-1:0];
		sel_bypass = fld[7][1:0];
		@(negedge clk);
		check_value("result_valid_o", 32'(result_valid), 32'd1);
		check_value("result_o", result, fld[8]);
		check_value("comparison_o", 32'(comparison), fld[9]);
		check_value("err_corrected_o", 32'(err_corrected), fld[10]);
		check_value("err_detected_o", 32'(err_detected), fld[11]);
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			req[r].en = 1'b0;
		end
	endtask

	task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat);
		int waited;
		@(negedge clk);
		wb = {1'b1, 1'b1, we, adr[ADDR_W-1:0], dat};
		@(negedge clk);
		waited = 1;
		while (!wb_ack && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack) begin
			errors++;
			$display("no Wishbone ack within 4 cycles for address %h", adr);
		end else begin
			if (!we) begin
				check_value("wb_dat_o", wb_dat, dat);
				if (adr == 32'(REG_FLAGS_ADDR)) begin
					check_value("faulty_o", 32'(faulty), dat);  // mirrors the flag register
				end
			end
			@(negedge clk);  // stb stays up over the edge that samples ack
			check_value("wb_ack_o", 32'(wb_ack), 32'd0);
		end
		wb = '0;
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin
		string line;
		byte   kind;
		int    fd;
		clk        = 1'b0;
		rst_i      = 1'b1;
		req        = '0;
		sel_spare  = '0;
		sel_bypass = '0;
		wb         = '0;
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open tb_input.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		limit = 8 * lines.size() + 10 + 50;
		repeat (10) @(negedge clk);
		rst_i = 1'b0;
		check_value("result_valid_o", 32'(result_valid), 32'd0);
		check_value("faulty_o", 32'(faulty), 32'd0);
		foreach (lines[i]) begin
			void'($sscanf(lines[i], "%c %h %h %h %h %h %h %h %h %h %h %h %h", kind,
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
				fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]));
			case (kind)
				"A": issue_op();
				"R": wb_cycle(1'b0, fld[0], fld[1]);
				"W": wb_cycle(1'b1, fld[0], fld[1]);
				default: begin
					errors++;
					$display("unknown line kind in tb_input.txt: %s", lines[i]);
				end
			endcase
		end
		repeat (2) @(negedge clk);
		errors += u_ft_alu_top.u_ft_alu_sva.fails;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: tb_input.txt
# A op a0 a1 a2 a3 b spare bypass result cmp corrected detected
# R addr expected_data / W addr data, all fields hex
A 0 5 5 5 5 3 0 0 8 0 0 0
A 1 7 7 7 7 7 0 0 0 1 0 0
A 2 f0f0 f0f0 f0f0 f0f0 0ff0 0 0 f0 0 0 0
A 3 f000 f000 f000 f000 f 0 0 f00f 0 0 0
A 4 ffff ffff ffff ffff 0f0f 0 0 f0f0 0 0 0
A 5 1 1 1 1 4 0 0 10 0 0 0
A 6 80000000 80000000 80000000 80000000 1f 0 0 1 0 0 0
A 7 ffffffff ffffffff ffffffff ffffffff 1 0 0 1 1 0 0
A 8 ffffffff ffffffff ffffffff ffffffff 1 0 0 0 0 0 0
A 0 10 20 10 10 1 0 0 11 0 1 1
R 1 1
A 0 99 10 10 10 1 1 0 11 0 0 0
A 0 10 10 10 99 1 1 0 11 0 1 1
R 3 1
A 0 10 20 10 10 1 0 0 11 0 1 1
A 0 10 20 10 10 1 0 0 11 0 1 1
A 0 10 20 10 10 1 0 0 11 0 1 1
R 4 2
W 1 0
R 4 0
A 0 1 2 4 4 0 0 0 0 0 0 1
A 0 10 20 10 10 1 0 2 21 0 1 1

// File: tmr_voter.sv
module tmr_voter import ft_alu_pkg::*; (
	input  alu_rsp_t [NUM_SLOTS-1:0] slot_i,
	output alu_rsp_t                 voted_o,
	output logic [NUM_SLOTS-1:0]     mismatch_o,
	output logic                     no_majority_o
);

	// bit by bit two out of three, valid and flag are voted as well
	assign voted_o = (slot_i[0] & slot_i[1])
	               | (slot_i[0] & slot_i[2])
	               | (slot_i[1] & slot_i[2]);

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			mismatch_o[k] = (slot_i[k] != voted_o);
		end
	end

	// no two slots agree, the voted word is a mix of all three
	assign no_majority_o = (slot_i[0] != slot_i[1])
	                     & (slot_i[0] != slot_i[2])
	                     & (slot_i[1] != slot_i[2]);

endmodule
